// ==== flist.f ====
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/ctrl_if.sv
verilog/control.sv
verilog/pc_npc.sv
verilog/rf.sv
verilog/exec_unit.sv
verilog/single_cycle_cpu.sv
tb/cpu_chk.sv
tb/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation passed" sim.log; then
	exit 0
fi
exit 1

// ==== tb/cpu_chk.sv ====
module cpu_chk (
	input logic        clk,
	input logic        arst_n,
	input logic [31:0] imem_addr,
	input logic [31:0] imem_rdata,
	input logic [31:0] dmem_addr,
	input logic [31:0] dmem_wdata,
	input logic        dmem_we,
	input logic [31:0] dmem_rdata,
	input logic        rf_we,
	input logic [4:0]  rf_waddr,
	input logic [31:0] rf_wdata
);

	int          fail_count = 0;
	logic [31:0] shadow [0:31];
	logic [5:0]  op;
	logic [5:0]  funct;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm;
	logic [31:0] sh_rs;
	logic [31:0] sh_rt;
	logic [31:0] sext;
	logic        exp_rf_we;
	logic        exp_dm_we;
	logic        exp_mem;
	logic [4:0]  exp_waddr;
	logic [31:0] exp_wdata;
	logic [31:0] exp_addr;
	logic [31:0] exp_npc;

	assign op    = imem_rdata[isa_pkg::op_msb:isa_pkg::op_lsb];
	assign funct = imem_rdata[isa_pkg::funct_msb:isa_pkg::funct_lsb];
	assign rs    = imem_rdata[isa_pkg::rs_msb:isa_pkg::rs_lsb];
	assign rt    = imem_rdata[isa_pkg::rt_msb:isa_pkg::rt_lsb];
	assign rd    = imem_rdata[isa_pkg::rd_msb:isa_pkg::rd_lsb];
	assign imm   = imem_rdata[isa_pkg::imm16_msb:isa_pkg::imm16_lsb];
	assign sext  = {{16{imm[15]}}, imm};
	assign sh_rs = shadow[rs];
	assign sh_rt = shadow[rt];
	assign exp_addr = sh_rs + sext;

	// ----------------------------------------
	// Shadow register file with zero held at zero.
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				shadow[i] <= '0;
			end
		end else if (rf_we && rf_waddr != 5'd0) begin
			shadow[rf_waddr] <= rf_wdata;
		end
	end

	// Architectural result of the current instruction.
	always_comb begin
		exp_rf_we = 1'b0;
		exp_dm_we = 1'b0;
		exp_mem   = 1'b0;
		exp_waddr = rt;
		exp_wdata = '0;
		exp_npc   = imem_addr + 32'd4;
		case (op)
			isa_pkg::op_rtype: begin
				if (funct == isa_pkg::funct_addu || funct == isa_pkg::funct_subu) begin
					exp_rf_we = 1'b1;
					exp_waddr = rd;
					exp_wdata = (funct == isa_pkg::funct_addu) ? sh_rs + sh_rt : sh_rs - sh_rt;
				end
			end
			isa_pkg::op_lui: begin
				exp_rf_we = 1'b1;
				exp_wdata = {imm, 16'h0000};
			end
			isa_pkg::op_ori: begin
				exp_rf_we = 1'b1;
				exp_wdata = sh_rs | {16'h0000, imm};
			end
			isa_pkg::op_lw: begin
				exp_rf_we = 1'b1;
				exp_mem   = 1'b1;
				exp_wdata = dmem_rdata;
			end
			isa_pkg::op_sw: begin
				exp_dm_we = 1'b1;
				exp_mem   = 1'b1;
			end
			isa_pkg::op_beq: begin
				if (sh_rs == sh_rt) begin
					exp_npc = imem_addr + 32'd4 + {sext[29:0], 2'b00};
				end
			end
			default: begin
			end
		endcase
	end

	// ----------------------------------------
	// Assertions.
	// ----------------------------------------
	a_rf_we: assert property (@(posedge clk) disable iff (!arst_n) rf_we == exp_rf_we)
		else begin
			fail_count++;
			$error("error rf_we %h expected %h", $sampled(rf_we), $sampled(exp_rf_we));
		end

	a_rf_waddr: assert property (@(posedge clk) disable iff (!arst_n)
		exp_rf_we |-> rf_waddr == exp_waddr)
		else begin
			fail_count++;
			$error("error rf_waddr %h expected %h", $sampled(rf_waddr), $sampled(exp_waddr));
		end

	a_rf_wdata: assert property (@(posedge clk) disable iff (!arst_n)
		exp_rf_we |-> rf_wdata == exp_wdata)
		else begin
			fail_count++;
			$error("error rf_wdata %h expected %h", $sampled(rf_wdata), $sampled(exp_wdata));
		end

	a_dmem_we: assert property (@(posedge clk) disable iff (!arst_n) dmem_we == exp_dm_we)
		else begin
			fail_count++;
			$error("error dmem_we %h expected %h", $sampled(dmem_we), $sampled(exp_dm_we));
		end

	a_dmem_addr: assert property (@(posedge clk) disable iff (!arst_n)
		exp_mem |-> dmem_addr == exp_addr)
		else begin
			fail_count++;
			$error("error dmem_addr %h expected %h", $sampled(dmem_addr), $sampled(exp_addr));
		end

	a_dmem_wdata: assert property (@(posedge clk) disable iff (!arst_n)
		exp_dm_we |-> dmem_wdata == sh_rt)
		else begin
			fail_count++;
			$error("error dmem_wdata %h expected %h", $sampled(dmem_wdata), $sampled(sh_rt));
		end

	// Next fetch follows the branch rule.
	a_npc: assert property (@(posedge clk) disable iff (!arst_n)
		1'b1 |=> imem_addr == $past(exp_npc))
		else begin
			fail_count++;
			$error("error imem_addr %h expected %h", $sampled(imem_addr), $past(exp_npc));
		end

	a_reset_pc: assert property (@(posedge clk)
		$rose(arst_n) |-> imem_addr == isa_pkg::reset_pc)
		else begin
			fail_count++;
			$error("error imem_addr %h expected %h after reset", $sampled(imem_addr),
				isa_pkg::reset_pc);
		end

endmodule

// ==== tb/tb_top.sv ====
module tb_top;

	localparam int max_cycles = 100;
	localparam logic [31:0] final_pc = isa_pkg::reset_pc + 32'd252;

	logic        clk;
	logic        arst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic [31:0] dmem_rdata;
	logic        rf_we;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:63];
	logic [31:0] rng_state;
	logic [31:0] imem_off;
	int          cycles;

	single_cycle_cpu uut (
		.clk        (clk),
		.arst_n     (arst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata),
		.rf_we      (rf_we),
		.rf_waddr   (rf_waddr),
		.rf_wdata   (rf_wdata)
	);

	bind single_cycle_cpu cpu_chk u_chk (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// Memory models with asynchronous reads.
	// ----------------------------------------
	assign imem_off   = imem_addr - isa_pkg::reset_pc;
	assign imem_rdata = imem[imem_off[7:2]];
	assign dmem_rdata = dmem[dmem_addr[7:2]];

	always @(posedge clk) begin
		if (arst_n && dmem_we) begin
			dmem[dmem_addr[7:2]] <= dmem_wdata;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng_state = xorshift(rng_state);
		r = rng_state;
	endtask

	// Random program of forward branches that ends in a self loop.
	task automatic build_program();
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] k;
		for (int i = 0; i < 63; i++) begin
			next_rand(r);
			next_rand(s);
			case (r % 9)
				0: imem[i] = {isa_pkg::op_rtype, r[4:0], r[9:5], r[14:10], 5'd0,
					isa_pkg::funct_addu};
				1: imem[i] = {isa_pkg::op_rtype, r[4:0], r[9:5], r[14:10], 5'd0,
					isa_pkg::funct_subu};
				2: imem[i] = {isa_pkg::op_lui, 5'd0, r[9:5], s[15:0]};
				3: imem[i] = {isa_pkg::op_ori, r[4:0], r[9:5], s[15:0]};
				4: imem[i] = {isa_pkg::op_lw, 5'd0, r[9:5], 8'h00, s[7:2], 2'b00};
				5: imem[i] = {isa_pkg::op_sw, 5'd0, r[9:5], 8'h00, s[7:2], 2'b00};
				6: begin
					k = s % 4;
					if (k > 32'(62 - i)) begin
						k = 32'(62 - i);
					end
					// Few registers so that some branches are taken.
					imem[i] = {isa_pkg::op_beq, 3'd0, r[1:0], 3'd0, r[3:2], k[15:0]};
				end
				7: imem[i] = 32'h0000_0000;
				default: imem[i] = {6'h3f, s[25:0]};
			endcase
		end
		imem[63] = {isa_pkg::op_beq, 5'd0, 5'd0, 16'hffff};
		for (int i = 0; i < 64; i++) begin
			dmem[i] = (32'(i) * 32'd4) * 32'h9e37_79b1 ^ 32'hc001_d00d;
		end
	endtask

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// ----------------------------------------
	// Reset, run and end of test.
	// ----------------------------------------
	initial begin
		arst_n    = 1'b0;
		rng_state = 32'd99;
		cycles    = 0;
		build_program();
		repeat (16) begin
			@(negedge clk);
			cycles++;
		end
		arst_n = 1'b1;
		forever begin
			@(negedge clk);
			cycles++;
			if (uut.u_chk.fail_count != 0) begin
				stop_failed("checker reported a wrong result");
			end else if (imem_addr == final_pc) begin
				// Two more edges judge the jump into the loop and the loop itself.
				repeat (2) @(negedge clk);
				if (uut.u_chk.fail_count != 0) begin
					stop_failed("checker reported a wrong result");
				end else begin
					$display("Simulation passed");
					$finish;
				end
			end else if (cycles >= max_cycles) begin
				stop_failed("timeout before the program reached its final loop");
			end
		end
	end

endmodule

// ==== verilog/control.sv ====
module control (
	input  logic [31:0] instr,
	ctrl_if.drv         ctl
);

	logic [5:0]           op;
	logic [5:0]           funct;
	isa_pkg::instr_kind_t kind;

	assign op    = instr[isa_pkg::op_msb:isa_pkg::op_lsb];
	assign funct = instr[isa_pkg::funct_msb:isa_pkg::funct_lsb];

	// ----------------------------------------
	// Instruction classification.
	// ----------------------------------------
	always_comb begin
		case (op)
			isa_pkg::op_rtype: begin
				case (funct)
					isa_pkg::funct_addu: kind = isa_pkg::kind_addu;
					isa_pkg::funct_subu: kind = isa_pkg::kind_subu;
					isa_pkg::funct_nop:  kind = isa_pkg::kind_nop;
					default:             kind = isa_pkg::kind_unknown;
				endcase
			end
			isa_pkg::op_lui: kind = isa_pkg::kind_lui;
			isa_pkg::op_ori: kind = isa_pkg::kind_ori;
			isa_pkg::op_lw:  kind = isa_pkg::kind_lw;
			isa_pkg::op_sw:  kind = isa_pkg::kind_sw;
			isa_pkg::op_beq: kind = isa_pkg::kind_beq;
			default:         kind = isa_pkg::kind_unknown;
		endcase
	end

	// ----------------------------------------
	// Control word.
	// ----------------------------------------
	always_comb begin
		// Safe defaults, nothing written.
		ctl.alu_op    = ctrl_pkg::alu_or;
		ctl.ext_mode  = ctrl_pkg::ext_zero;
		ctl.opnd_sel  = ctrl_pkg::opnd_rt;
		ctl.npc_mode  = ctrl_pkg::npc_seq;
		ctl.rf_we     = 1'b0;
		ctl.dm_we     = 1'b0;
		ctl.waddr_sel = ctrl_pkg::waddr_rt;
		ctl.wdata_sel = ctrl_pkg::wdata_alu;

		case (kind)
			isa_pkg::kind_addu, isa_pkg::kind_subu: begin
				ctl.alu_op    = (kind == isa_pkg::kind_addu) ? ctrl_pkg::alu_add
				                                             : ctrl_pkg::alu_sub;
				ctl.rf_we     = 1'b1;
				ctl.waddr_sel = ctrl_pkg::waddr_rd;
			end
			isa_pkg::kind_lui: begin
				ctl.ext_mode = ctrl_pkg::ext_pad;
				ctl.opnd_sel = ctrl_pkg::opnd_imm;
				ctl.rf_we    = 1'b1;
			end
			isa_pkg::kind_ori: begin
				ctl.opnd_sel = ctrl_pkg::opnd_imm;
				ctl.rf_we    = 1'b1;
			end
			isa_pkg::kind_lw: begin
				ctl.alu_op    = ctrl_pkg::alu_add;
				ctl.ext_mode  = ctrl_pkg::ext_sign;
				ctl.opnd_sel  = ctrl_pkg::opnd_imm;
				ctl.rf_we     = 1'b1;
				ctl.wdata_sel = ctrl_pkg::wdata_mem;
			end
			isa_pkg::kind_sw: begin
				ctl.alu_op   = ctrl_pkg::alu_add;
				ctl.ext_mode = ctrl_pkg::ext_sign;
				ctl.opnd_sel = ctrl_pkg::opnd_imm;
				ctl.dm_we    = 1'b1;
			end
			isa_pkg::kind_beq: ctl.npc_mode = ctrl_pkg::npc_beq;
			default: begin
				// nop and unknown keep the defaults
			end
		endcase
	end

endmodule

// ==== verilog/ctrl_if.sv ====
interface ctrl_if;

	// Datapath controls.
	ctrl_pkg::alu_op_t    alu_op;
	ctrl_pkg::ext_mode_t  ext_mode;
	ctrl_pkg::opnd_sel_t  opnd_sel;
	ctrl_pkg::npc_mode_t  npc_mode;

	// Write strobes and write-back selects.
	logic                 rf_we;
	logic                 dm_we;
	ctrl_pkg::wsel_addr_t waddr_sel;
	ctrl_pkg::wsel_data_t wdata_sel;

	modport drv (
		output alu_op, ext_mode, opnd_sel, npc_mode,
		output rf_we, dm_we, waddr_sel, wdata_sel
	);

	modport ex (input alu_op, ext_mode, opnd_sel);

	modport pc (input npc_mode);

endinterface

// ==== verilog/ctrl_pkg.sv ====
package ctrl_pkg;

	// ----------------------------------------
	// Datapath control fields.
	// ----------------------------------------
	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_or
	} alu_op_t;

	// ext_pad puts imm16 in the upper half, low half zero.
	typedef enum logic [1:0] {
		ext_zero,
		ext_sign,
		ext_pad
	} ext_mode_t;

	typedef enum logic {
		npc_seq,
		npc_beq
	} npc_mode_t;

	typedef enum logic {
		opnd_rt,
		opnd_imm
	} opnd_sel_t;

	// ----------------------------------------
	// Write-back selects.
	// ----------------------------------------
	typedef enum logic {
		waddr_rt,
		waddr_rd
	} wsel_addr_t;

	typedef enum logic {
		wdata_alu,
		wdata_mem
	} wsel_data_t;

endpackage

// ==== verilog/exec_unit.sv ====
module exec_unit (
	ctrl_if.ex          ctl,
	input  logic [31:0] rs_val,
	input  logic [31:0] rt_val,
	input  logic [15:0] imm16,
	output logic [31:0] result,
	output logic        equal
);

	logic [31:0] ext_imm;
	logic [31:0] opnd_b;

	// ----------------------------------------
	// Immediate extension.
	// ----------------------------------------
	always_comb begin
		case (ctl.ext_mode)
			ctrl_pkg::ext_sign: ext_imm = {{16{imm16[15]}}, imm16};
			ctrl_pkg::ext_pad:  ext_imm = {imm16, 16'h0000};
			default:            ext_imm = {16'h0000, imm16};
		endcase
	end

	// Second operand.
	assign opnd_b = (ctl.opnd_sel == ctrl_pkg::opnd_imm) ? ext_imm : rt_val;

	// ----------------------------------------
	// ALU.
	// ----------------------------------------
	always_comb begin
		case (ctl.alu_op)
			ctrl_pkg::alu_add: result = rs_val + opnd_b;
			ctrl_pkg::alu_sub: result = rs_val - opnd_b;
			default:           result = rs_val | opnd_b;
		endcase
	end

	// Branch compare, always on the two register reads.
	assign equal = (rs_val == rt_val);

endmodule

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

	// ----------------------------------------
	// Instruction field positions.
	// ----------------------------------------
	localparam int op_msb    = 31;
	localparam int op_lsb    = 26;
	localparam int rs_msb    = 25;
	localparam int rs_lsb    = 21;
	localparam int rt_msb    = 20;
	localparam int rt_lsb    = 16;
	localparam int rd_msb    = 15;
	localparam int rd_lsb    = 11;
	localparam int funct_msb = 5;
	localparam int funct_lsb = 0;
	localparam int imm16_msb = 15;
	localparam int imm16_lsb = 0;

	// ----------------------------------------
	// Opcode and funct encodings.
	// ----------------------------------------
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;
	localparam logic [5:0] op_beq   = 6'h04;

	localparam logic [5:0] funct_addu = 6'h21;
	localparam logic [5:0] funct_subu = 6'h23;
	localparam logic [5:0] funct_nop  = 6'h00;

	// Decoded instruction class.
	typedef enum logic [3:0] {
		kind_addu,
		kind_subu,
		kind_lui,
		kind_ori,
		kind_lw,
		kind_sw,
		kind_beq,
		kind_nop,
		kind_unknown
	} instr_kind_t;

	// First fetch address out of reset.
	localparam logic [31:0] reset_pc = 32'h0000_3000;

endpackage

// ==== verilog/pc_npc.sv ====
module pc_npc (
	input  logic        clk,
	input  logic        arst_n,
	ctrl_if.pc          ctl,
	input  logic [15:0] imm16,
	input  logic        equal,
	output logic [31:0] pc
);

	logic [31:0] pc_plus4;
	logic [31:0] br_offset;
	logic [31:0] br_target;
	logic [31:0] npc;

	assign pc_plus4 = pc + 32'd4;

	// Word offset, sign-extended.
	assign br_offset = {{14{imm16[15]}}, imm16, 2'b00};
	assign br_target = pc_plus4 + br_offset;

	always_comb begin
		if (ctl.npc_mode == ctrl_pkg::npc_beq && equal) begin
			npc = br_target;
		end else begin
			npc = pc_plus4;
		end
	end

	// ----------------------------------------
	// PC register.
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= isa_pkg::reset_pc;
		end else begin
			pc <= npc;
		end
	end

endmodule

// ==== verilog/rf.sv ====
module rf (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic [4:0]  wa,
	input  logic        we,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [0:31];

	// ----------------------------------------
	// Write port.
	// ----------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// ----------------------------------------
	// Read ports, asynchronous.
	// ----------------------------------------
	always_comb begin
		if (ra1 == 5'd0) begin
			rd1 = '0;
		end else begin
			rd1 = regs[ra1];
		end
	end

	always_comb begin
		if (ra2 == 5'd0) begin
			rd2 = '0;
		end else begin
			rd2 = regs[ra2];
		end
	end

endmodule

// ==== verilog/single_cycle_cpu.sv ====
module single_cycle_cpu (
	input  logic        clk,
	input  logic        arst_n,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_rdata,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	input  logic [31:0] dmem_rdata,
	output logic        rf_we,
	output logic [4:0]  rf_waddr,
	output logic [31:0] rf_wdata
);

	logic [31:0] pc;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm16;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] result;
	logic        equal;

	ctrl_if ctl ();

	// ----------------------------------------
	// Fetch and field slicing.
	// ----------------------------------------
	assign imem_addr = pc;

	assign rs    = imem_rdata[isa_pkg::rs_msb:isa_pkg::rs_lsb];
	assign rt    = imem_rdata[isa_pkg::rt_msb:isa_pkg::rt_lsb];
	assign rd    = imem_rdata[isa_pkg::rd_msb:isa_pkg::rd_lsb];
	assign imm16 = imem_rdata[isa_pkg::imm16_msb:isa_pkg::imm16_lsb];

	control u_control (
		.instr (imem_rdata),
		.ctl   (ctl)
	);

	pc_npc u_pc_npc (
		.clk    (clk),
		.arst_n (arst_n),
		.ctl    (ctl),
		.imm16  (imm16),
		.equal  (equal),
		.pc     (pc)
	);

	rf u_rf (
		.clk    (clk),
		.arst_n (arst_n),
		.ra1    (rs),
		.ra2    (rt),
		.wa     (rf_waddr),
		.we     (rf_we),
		.wd     (rf_wdata),
		.rd1    (rs_val),
		.rd2    (rt_val)
	);

	exec_unit u_exec_unit (
		.ctl    (ctl),
		.rs_val (rs_val),
		.rt_val (rt_val),
		.imm16  (imm16),
		.result (result),
		.equal  (equal)
	);

	// ----------------------------------------
	// Memory port and write-back.
	// ----------------------------------------
	assign dmem_addr  = result;
	assign dmem_wdata = rt_val;
	assign dmem_we    = ctl.dm_we;

	// Trace outputs are the register-file write inputs.
	assign rf_we    = ctl.rf_we;
	assign rf_waddr = (ctl.waddr_sel == ctrl_pkg::waddr_rd) ? rd : rt;
	assign rf_wdata = (ctl.wdata_sel == ctrl_pkg::wdata_mem) ? dmem_rdata : result;

endmodule
